//--- axi_copy_engine.f
+incdir+hw
hw/axi_copy_pkg.sv
hw/axi_burst_reader.sv
hw/burst_fifo.sv
hw/axi_burst_writer.sv
hw/axi_copy_engine.sv
tb/copy_checker.sv
tb/tb_axi_copy_engine.sv

//--- hw/axi_burst_reader.sv
`timescale 1ns/1ps
`include "axi_copy_defines.svh"

module axi_burst_reader (
	input logic clk,
	input logic rst,

	// Job control
	input logic go,
	input logic [`ADDR_WIDTH-1:0] src_addr,
	input logic [7:0] num_bursts,
	output logic rd_done,
	output logic rd_err,

	// FIFO fill level, used for the room check
	input logic [`LEVEL_WIDTH-1:0] level,

	// AR channel
	output logic [`ADDR_WIDTH-1:0] m_axi_araddr,
	output logic [7:0] m_axi_arlen,
	output logic m_axi_arvalid,
	input logic m_axi_arready,

	// R channel
	input logic [`DATA_WIDTH-1:0] m_axi_rdata,
	input logic [`ID_WIDTH-1:0] m_axi_rid,
	input logic [1:0] m_axi_rresp,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready,

	// Beats toward the FIFO
	output logic push,
	output logic [`DATA_WIDTH-1:0] push_data
);
	import axi_copy_pkg::*;

	localparam logic [`ADDR_WIDTH-1:0] BURST_BYTES =
		`ADDR_WIDTH'(`BURST_LEN * (`DATA_WIDTH / 8));
	// Highest level that still leaves a whole burst of free entries
	localparam logic [`LEVEL_WIDTH-1:0] ROOM_LIMIT = `LEVEL_WIDTH'(`FIFO_DEPTH - `BURST_LEN);

	rd_state_t state;
	logic [`ADDR_WIDTH-1:0] addr_q;
	logic [7:0] bursts_left;
	logic err_q;
	logic room;
	logic beat_bad;

	assign room = (level <= ROOM_LIMIT);

	// Every beat is forwarded, rready only rises in the data state
	assign push = m_axi_rvalid && m_axi_rready;
	assign push_data = m_axi_rdata;

	// Any ID other than zero is as bad as an error response
	assign beat_bad = push && ((m_axi_rresp != RESP_OKAY) || (m_axi_rid != '0));

	assign rd_done = push && m_axi_rlast && (bursts_left == 8'd1);
	assign rd_err = err_q || beat_bad;

	assign m_axi_araddr = addr_q;
	assign m_axi_arlen = 8'(`BURST_LEN - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RD_IDLE;
			m_axi_arvalid <= 1'b0;
			m_axi_rready <= 1'b0;
			err_q <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (go) begin
						err_q <= 1'b0;
						state <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					// Level can only fall here, so arvalid stays up once raised
					if (!m_axi_arvalid && room) begin
						m_axi_arvalid <= 1'b1;
					end else if (m_axi_arvalid && m_axi_arready) begin
						m_axi_arvalid <= 1'b0;
						m_axi_rready <= 1'b1;
						state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (beat_bad) begin
						err_q <= 1'b1;
					end
					if (push && m_axi_rlast) begin
						m_axi_rready <= 1'b0;
						state <= (bursts_left == 8'd1) ? RD_IDLE : RD_ADDR;
					end
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

	// Burst address and count, loaded at go
	always_ff @(posedge clk) begin
		if (state == RD_IDLE && go) begin
			addr_q <= src_addr;
			bursts_left <= num_bursts;
		end else if (push && m_axi_rlast) begin
			addr_q <= addr_q + BURST_BYTES;
			bursts_left <= bursts_left - 8'd1;
		end
	end

endmodule

//--- hw/axi_burst_writer.sv
`timescale 1ns/1ps
`include "axi_copy_defines.svh"

module axi_burst_writer (
	input logic clk,
	input logic rst,

	// Job control
	input logic go,
	input logic [`ADDR_WIDTH-1:0] dst_addr,
	input logic [7:0] num_bursts,
	output logic wr_done,
	output logic wr_err,

	// FIFO read side
	input logic [`LEVEL_WIDTH-1:0] level,
	input logic [`DATA_WIDTH-1:0] pop_data,
	output logic pop,

	// AW channel
	output logic [`ADDR_WIDTH-1:0] m_axi_awaddr,
	output logic [7:0] m_axi_awlen,
	output logic m_axi_awvalid,
	input logic m_axi_awready,

	// W channel
	output logic [`DATA_WIDTH-1:0] m_axi_wdata,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,

	// B channel
	input logic [`ID_WIDTH-1:0] m_axi_bid,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready
);
	import axi_copy_pkg::*;

	localparam int BEAT_WIDTH = $clog2(`BURST_LEN);
	localparam logic [`ADDR_WIDTH-1:0] BURST_BYTES =
		`ADDR_WIDTH'(`BURST_LEN * (`DATA_WIDTH / 8));
	localparam logic [`LEVEL_WIDTH-1:0] BURST_LEVEL = `LEVEL_WIDTH'(`BURST_LEN);

	wr_state_t state;
	logic [`ADDR_WIDTH-1:0] addr_q;
	logic [7:0] bursts_left;
	logic [BEAT_WIDTH-1:0] beat_cnt;
	logic err_q;
	logic b_fire;
	logic resp_bad;

	// A W beat transfer takes the FIFO head
	assign pop = m_axi_wvalid && m_axi_wready;
	assign m_axi_wdata = pop_data;
	assign m_axi_wlast = (beat_cnt == BEAT_WIDTH'(`BURST_LEN - 1));

	assign b_fire = m_axi_bvalid && m_axi_bready;
	assign resp_bad = b_fire && ((m_axi_bresp != RESP_OKAY) || (m_axi_bid != '0));

	assign wr_done = b_fire && (bursts_left == 8'd1);
	assign wr_err = err_q || resp_bad;

	assign m_axi_awaddr = addr_q;
	assign m_axi_awlen = 8'(`BURST_LEN - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WR_IDLE;
			m_axi_awvalid <= 1'b0;
			m_axi_wvalid <= 1'b0;
			m_axi_bready <= 1'b0;
			err_q <= 1'b0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (go) begin
						err_q <= 1'b0;
						state <= WR_WAIT_DATA;
					end
				end
				WR_WAIT_DATA: begin
					// Whole burst buffered, so W never starves mid-burst
					if (level >= BURST_LEVEL) begin
						m_axi_awvalid <= 1'b1;
						state <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (m_axi_awready) begin
						m_axi_awvalid <= 1'b0;
						m_axi_wvalid <= 1'b1;
						state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (pop && m_axi_wlast) begin
						m_axi_wvalid <= 1'b0;
						m_axi_bready <= 1'b1;
						state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (b_fire) begin
						m_axi_bready <= 1'b0;
						err_q <= err_q || resp_bad;
						state <= (bursts_left == 8'd1) ? WR_IDLE : WR_WAIT_DATA;
					end
				end
				default: begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	// Address, burst count and beat count
	always_ff @(posedge clk) begin
		if (state == WR_IDLE && go) begin
			addr_q <= dst_addr;
			bursts_left <= num_bursts;
		end else if (b_fire) begin
			addr_q <= addr_q + BURST_BYTES;
			bursts_left <= bursts_left - 8'd1;
		end
		if (m_axi_awvalid && m_axi_awready) begin
			beat_cnt <= '0;
		end else if (pop) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

endmodule

//--- hw/axi_copy_defines.svh
`ifndef AXI_COPY_DEFINES_SVH
`define AXI_COPY_DEFINES_SVH

// AXI port widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define ID_WIDTH 1

// Beats per burst, fixed for every AR and AW
`define BURST_LEN 8

// Beat buffer between reader and writer, two bursts deep
`define FIFO_DEPTH 16

// Level count must hold FIFO_DEPTH itself
`define LEVEL_WIDTH 5

`endif

//--- hw/axi_copy_engine.sv
`timescale 1ns/1ps
`include "axi_copy_defines.svh"

module axi_copy_engine (
	input logic clk,
	input logic rst,

	// Job control
	input logic start,
	input logic [`ADDR_WIDTH-1:0] src_addr,
	input logic [`ADDR_WIDTH-1:0] dst_addr,
	input logic [7:0] num_bursts,
	output logic busy,
	output logic done,
	output logic error,

	// AW channel
	output logic [`ID_WIDTH-1:0] m_axi_awid,
	output logic [`ADDR_WIDTH-1:0] m_axi_awaddr,
	output logic [7:0] m_axi_awlen,
	output logic [2:0] m_axi_awsize,
	output logic [1:0] m_axi_awburst,
	output logic m_axi_awlock,
	output logic [3:0] m_axi_awcache,
	output logic [2:0] m_axi_awprot,
	output logic [3:0] m_axi_awqos,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	// W channel
	output logic [`DATA_WIDTH-1:0] m_axi_wdata,
	output logic [`DATA_WIDTH/8-1:0] m_axi_wstrb,
	output logic m_axi_wlast,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	// B channel
	input logic [`ID_WIDTH-1:0] m_axi_bid,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready,
	// AR channel
	output logic [`ID_WIDTH-1:0] m_axi_arid,
	output logic [`ADDR_WIDTH-1:0] m_axi_araddr,
	output logic [7:0] m_axi_arlen,
	output logic [2:0] m_axi_arsize,
	output logic [1:0] m_axi_arburst,
	output logic m_axi_arlock,
	output logic [3:0] m_axi_arcache,
	output logic [2:0] m_axi_arprot,
	output logic [3:0] m_axi_arqos,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	// R channel
	input logic [`DATA_WIDTH-1:0] m_axi_rdata,
	input logic [`ID_WIDTH-1:0] m_axi_rid,
	input logic [1:0] m_axi_rresp,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready
);
	import axi_copy_pkg::*;

	logic go;
	logic push;
	logic pop;
	logic [`DATA_WIDTH-1:0] push_data;
	logic [`DATA_WIDTH-1:0] pop_data;
	logic [`LEVEL_WIDTH-1:0] level;
	logic rd_done;
	logic rd_err;
	logic wr_done;
	logic wr_err;

	////////////////////////////////////////////////////////////////////////////
	// Fixed fields of the combined port
	////////////////////////////////////////////////////////////////////////////

	assign m_axi_awid = '0;
	assign m_axi_awsize = SIZE_WORD;
	assign m_axi_awburst = BURST_INCR;
	assign m_axi_awlock = LOCK_NORMAL;
	assign m_axi_awcache = CACHE_DEFAULT;
	assign m_axi_awprot = PROT_DEFAULT;
	assign m_axi_awqos = QOS_NONE;
	assign m_axi_wstrb = '1;

	assign m_axi_arid = '0;
	assign m_axi_arsize = SIZE_WORD;
	assign m_axi_arburst = BURST_INCR;
	assign m_axi_arlock = LOCK_NORMAL;
	assign m_axi_arcache = CACHE_DEFAULT;
	assign m_axi_arprot = PROT_DEFAULT;
	assign m_axi_arqos = QOS_NONE;

	////////////////////////////////////////////////////////////////////////////
	// Job control
	////////////////////////////////////////////////////////////////////////////

	// Start while busy is dropped
	assign go = start && !busy;

	// Writer finishes last, after every read beat has been drained
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			done <= wr_done;
			if (go) begin
				busy <= 1'b1;
			end else if (wr_done) begin
				busy <= 1'b0;
			end
			if (go) begin
				error <= 1'b0;
			end else if ((rd_done && rd_err) || (wr_done && wr_err)) begin
				error <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read half, beat buffer, write half
	////////////////////////////////////////////////////////////////////////////

	axi_burst_reader u_reader (
		.clk(clk),
		.rst(rst),
		.go(go),
		.src_addr(src_addr),
		.num_bursts(num_bursts),
		.rd_done(rd_done),
		.rd_err(rd_err),
		.level(level),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arlen(m_axi_arlen),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rid(m_axi_rid),
		.m_axi_rresp(m_axi_rresp),
		.m_axi_rlast(m_axi_rlast),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready),
		.push(push),
		.push_data(push_data)
	);

	burst_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.pop_data(pop_data),
		.level(level)
	);

	axi_burst_writer u_writer (
		.clk(clk),
		.rst(rst),
		.go(go),
		.dst_addr(dst_addr),
		.num_bursts(num_bursts),
		.wr_done(wr_done),
		.wr_err(wr_err),
		.level(level),
		.pop_data(pop_data),
		.pop(pop),
		.m_axi_awaddr(m_axi_awaddr),
		.m_axi_awlen(m_axi_awlen),
		.m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_wdata(m_axi_wdata),
		.m_axi_wlast(m_axi_wlast),
		.m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bid(m_axi_bid),
		.m_axi_bresp(m_axi_bresp),
		.m_axi_bvalid(m_axi_bvalid),
		.m_axi_bready(m_axi_bready)
	);

endmodule

//--- hw/axi_copy_pkg.sv
package axi_copy_pkg;

	////////////////////////////////////////////////////////////////////////////
	// FSM states
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_t;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_WAIT_DATA,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	////////////////////////////////////////////////////////////////////////////
	// AXI encodings
	////////////////////////////////////////////////////////////////////////////

	// xRESP codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// AxBURST and AxSIZE, 4 bytes per beat
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [2:0] SIZE_WORD = 3'b010;

	// Fixed attributes on both address channels
	localparam logic LOCK_NORMAL = 1'b0;
	localparam logic [3:0] CACHE_DEFAULT = 4'b0011;
	localparam logic [2:0] PROT_DEFAULT = 3'b000;
	localparam logic [3:0] QOS_NONE = 4'b0000;

endpackage

//--- hw/burst_fifo.sv
`timescale 1ns/1ps
`include "axi_copy_defines.svh"

module burst_fifo (
	input logic clk,
	input logic rst,

	// Write side, from the reader
	input logic push,
	input logic [`DATA_WIDTH-1:0] push_data,

	// Read side, head is shown combinationally
	input logic pop,
	output logic [`DATA_WIDTH-1:0] pop_data,

	output logic [`LEVEL_WIDTH-1:0] level
);
	localparam int PTR_WIDTH = $clog2(`FIFO_DEPTH);

	logic [`DATA_WIDTH-1:0] mem [`FIFO_DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;

	assign pop_data = mem[rd_ptr];

	// Storage, no reset needed
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the copy engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f axi_copy_engine.f --top-module tb_axi_copy_engine \
	-Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Test failed, see sim.log"
	exit 1
fi
echo "Test passed"

//--- tb/copy_checker.sv
`timescale 1ns/1ps
`include "axi_copy_defines.svh"

module copy_checker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done,
	input logic error,
	input logic [`ADDR_WIDTH-1:0] src_addr,
	input logic [`ADDR_WIDTH-1:0] dst_addr,
	input logic [7:0] num_bursts,
	input logic [`ID_WIDTH-1:0] m_axi_arid, m_axi_awid,
	input logic [`ADDR_WIDTH-1:0] m_axi_araddr, m_axi_awaddr,
	input logic [7:0] m_axi_arlen, m_axi_awlen,
	input logic [2:0] m_axi_arsize, m_axi_awsize,
	input logic [1:0] m_axi_arburst, m_axi_awburst, m_axi_rresp, m_axi_bresp,
	input logic m_axi_arlock, m_axi_awlock,
	input logic [3:0] m_axi_arcache, m_axi_awcache, m_axi_arqos, m_axi_awqos,
	input logic [2:0] m_axi_arprot, m_axi_awprot,
	input logic [`DATA_WIDTH/8-1:0] m_axi_wstrb,
	input logic m_axi_arvalid, m_axi_arready, m_axi_awvalid, m_axi_awready,
	input logic m_axi_rvalid, m_axi_rready, m_axi_wvalid, m_axi_wready, m_axi_wlast,
	input logic m_axi_bvalid, m_axi_bready,
	output int data_errors,
	output int proto_errors
);
	import axi_copy_pkg::*;

	logic active;
	logic accept;
	logic exp_error;
	logic [`ADDR_WIDTH-1:0] exp_araddr;
	logic [`ADDR_WIDTH-1:0] exp_awaddr;
	int job_bursts;
	int r_beats;
	int w_beats;

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
			proto_errors++;
		end
	endtask

	// Called by the testbench for each destination word after done
	task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error mem[0x%08h]: got 0x%08h expected 0x%08h", addr, got, exp);
			data_errors++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			active = 1'b0;
			exp_error = 1'b0;
		end else begin
			// DUT takes a start whenever busy is low, which includes the done cycle
			accept = start && !(active && !done);
			check_field("busy", busy, active && !done);
			if (done && !active) begin
				$display("Error: done pulsed with no job running at %0t", $time);
				proto_errors++;
			end
			if (m_axi_arvalid && m_axi_arready) begin
				check_field("m_axi_araddr", m_axi_araddr, exp_araddr);
				check_field("m_axi_arlen", m_axi_arlen, `BURST_LEN - 1);
				check_field("m_axi_arsize", m_axi_arsize, SIZE_WORD);
				check_field("m_axi_arburst", m_axi_arburst, BURST_INCR);
				check_field("m_axi_arid", m_axi_arid, 0);
				check_field("m_axi_arlock", m_axi_arlock, LOCK_NORMAL);
				check_field("m_axi_arcache", m_axi_arcache, CACHE_DEFAULT);
				check_field("m_axi_arprot", m_axi_arprot, PROT_DEFAULT);
				check_field("m_axi_arqos", m_axi_arqos, QOS_NONE);
				exp_araddr = exp_araddr + 4 * `BURST_LEN;
			end
			if (m_axi_awvalid && m_axi_awready) begin
				check_field("m_axi_awaddr", m_axi_awaddr, exp_awaddr);
				check_field("m_axi_awlen", m_axi_awlen, `BURST_LEN - 1);
				check_field("m_axi_awsize", m_axi_awsize, SIZE_WORD);
				check_field("m_axi_awburst", m_axi_awburst, BURST_INCR);
				check_field("m_axi_awid", m_axi_awid, 0);
				check_field("m_axi_awlock", m_axi_awlock, LOCK_NORMAL);
				check_field("m_axi_awcache", m_axi_awcache, CACHE_DEFAULT);
				check_field("m_axi_awprot", m_axi_awprot, PROT_DEFAULT);
				check_field("m_axi_awqos", m_axi_awqos, QOS_NONE);
				exp_awaddr = exp_awaddr + 4 * `BURST_LEN;
			end
			if (m_axi_rvalid && m_axi_rready) begin
				r_beats++;
				if (m_axi_rresp != RESP_OKAY) begin
					exp_error = 1'b1;
				end
			end
			if (m_axi_wvalid && m_axi_wready) begin
				w_beats++;
				check_field("m_axi_wlast", m_axi_wlast, (w_beats % `BURST_LEN) == 0);
				// Full words only
				check_field("m_axi_wstrb", m_axi_wstrb, {(`DATA_WIDTH / 8){1'b1}});
			end
			if (m_axi_bvalid && m_axi_bready && m_axi_bresp != RESP_OKAY) begin
				exp_error = 1'b1;
			end
			// Job end
			if (done && active) begin
				check_field("R beat count", r_beats, job_bursts * `BURST_LEN);
				check_field("W beat count", w_beats, job_bursts * `BURST_LEN);
				check_field("error", error, exp_error);
				active = 1'b0;
			end
			if (accept) begin
				active = 1'b1;
				exp_error = 1'b0;
				exp_araddr = src_addr;
				exp_awaddr = dst_addr;
				job_bursts = num_bursts;
				r_beats = 0;
				w_beats = 0;
			end
		end
	end

endmodule

//--- tb/tb_axi_copy_engine.sv
`timescale 1ns/1ps
`include "axi_copy_defines.svh"

module tb_axi_copy_engine;
	import axi_copy_pkg::*;

	localparam int NUM_JOBS = 12;
	localparam int TIMEOUT = 4000;

	logic clk;
	logic rst;
	logic start;
	logic [`ADDR_WIDTH-1:0] src_addr;
	logic [`ADDR_WIDTH-1:0] dst_addr;
	logic [7:0] num_bursts;
	logic busy;
	logic done;
	logic error;
	int data_errors;
	int proto_errors;

	// AXI master port
	logic [`ID_WIDTH-1:0] m_axi_awid, m_axi_bid, m_axi_arid, m_axi_rid;
	logic [`ADDR_WIDTH-1:0] m_axi_awaddr, m_axi_araddr;
	logic [`DATA_WIDTH-1:0] m_axi_wdata, m_axi_rdata;
	logic [`DATA_WIDTH/8-1:0] m_axi_wstrb;
	logic [7:0] m_axi_awlen, m_axi_arlen;
	logic [3:0] m_axi_awcache, m_axi_awqos, m_axi_arcache, m_axi_arqos;
	logic [2:0] m_axi_awsize, m_axi_awprot, m_axi_arsize, m_axi_arprot;
	logic [1:0] m_axi_awburst, m_axi_arburst, m_axi_bresp, m_axi_rresp;
	logic m_axi_awlock, m_axi_awvalid, m_axi_awready, m_axi_wlast, m_axi_wvalid, m_axi_wready;
	logic m_axi_bvalid, m_axi_bready, m_axi_arlock, m_axi_arvalid, m_axi_arready;
	logic m_axi_rlast, m_axi_rvalid, m_axi_rready;

	// Slave memory, reference memory and slave state
	logic [31:0] mem [int unsigned];
	logic [31:0] ref_mem [int unsigned];
	integer seed;
	logic [31:0] rd_addr;
	logic [31:0] wr_addr;
	int rd_left;
	logic wr_open;
	logic b_due;
	logic r_taken;
	logic b_taken;
	logic err_job;
	logic b_err_owed;

	axi_copy_engine DUT (.*);

	copy_checker copy_checker (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f96;
	endfunction

	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		return mem.exists(addr) ? mem[addr] : fill_word(addr);
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
	endfunction

	function automatic logic chance(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// AXI slave, decides on the falling edge for the next rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (r_taken) begin
			m_axi_rvalid = 1'b0;
			rd_addr = rd_addr + 4;
			rd_left = rd_left - 1;
		end
		if (!m_axi_rvalid && rd_left > 0 && chance(70)) begin
			m_axi_rvalid = 1'b1;
			m_axi_rdata = mem_read(rd_addr);
			m_axi_rlast = (rd_left == 1);
			m_axi_rresp = (err_job && ($random(seed) & 63) == 0) ? RESP_SLVERR : RESP_OKAY;
		end
		m_axi_arready = (rd_left == 0) && chance(70);
		if (m_axi_arvalid && m_axi_arready) begin
			rd_addr = m_axi_araddr;
			rd_left = `BURST_LEN;
		end
		r_taken = m_axi_rvalid && m_axi_rready;

		if (b_taken) begin
			m_axi_bvalid = 1'b0;
		end
		if (b_due && chance(70)) begin
			m_axi_bvalid = 1'b1;
			m_axi_bresp = b_err_owed ? RESP_SLVERR : RESP_OKAY;
			b_err_owed = 1'b0;
			b_due = 1'b0;
		end
		m_axi_wready = wr_open && chance(70);
		if (m_axi_wvalid && m_axi_wready) begin
			mem[wr_addr] = m_axi_wdata;
			wr_addr = wr_addr + 4;
			if (m_axi_wlast) begin
				wr_open = 1'b0;
				b_due = 1'b1;
			end
		end
		m_axi_awready = !wr_open && !b_due && !m_axi_bvalid && chance(70);
		if (m_axi_awvalid && m_axi_awready) begin
			wr_addr = m_axi_awaddr;
			wr_open = 1'b1;
		end
		b_taken = m_axi_bvalid && m_axi_bready;
	end

	////////////////////////////////////////////////////////////////////////////
	// Jobs
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int nb;
		int cycles;
		logic [31:0] src;
		logic [31:0] dst;
		logic stray;
		seed = 32'h9cda_638f;
		rst = 1'b1;
		start = 1'b0;
		src_addr = '0;
		dst_addr = '0;
		num_bursts = 8'd1;
		m_axi_arready = 1'b0;
		m_axi_rvalid = 1'b0;
		m_axi_rdata = '0;
		m_axi_rid = '0;
		m_axi_rresp = RESP_OKAY;
		m_axi_rlast = 1'b0;
		m_axi_awready = 1'b0;
		m_axi_wready = 1'b0;
		m_axi_bvalid = 1'b0;
		m_axi_bid = '0;
		m_axi_bresp = RESP_OKAY;
		rd_left = 0;
		wr_open = 1'b0;
		b_due = 1'b0;
		r_taken = 1'b0;
		b_taken = 1'b0;
		err_job = 1'b0;
		b_err_owed = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int job = 0; job < NUM_JOBS; job++) begin
			// Draw job values between edges, away from the slave's draws
			@(posedge clk);
			nb = 1 + $unsigned($random(seed)) % 6;
			src = 32'h1000_0000 + job * 32'h1000 + ($random(seed) & 32'h3fc);
			dst = 32'h2000_0000 + job * 32'h1000 + ($random(seed) & 32'h3fc);
			@(negedge clk);
			// Every third job sees SLVERR, always on its first B
			err_job = (job % 3 == 1);
			b_err_owed = err_job;
			src_addr = src;
			dst_addr = dst;
			num_bursts = 8'(nb);
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;

			// Stray starts at random points while busy, all must be ignored
			cycles = 0;
			while (!done && cycles < TIMEOUT) begin
				@(posedge clk);
				stray = chance(10);
				@(negedge clk);
				start = stray && !done;
				src_addr = src + 32'h100;
				cycles++;
			end
			if (!done) begin
				$display("Timeout: job %0d gave no done within %0d cycles", job, TIMEOUT);
				$display("Simulation finished: FAIL");
				$finish;
			end

			for (int i = 0; i < nb * `BURST_LEN; i++) begin
				ref_mem[dst + 4 * i] = ref_read(src + 4 * i);
				copy_checker.check_word(dst + 4 * i, mem_read(dst + 4 * i), ref_read(dst + 4 * i));
			end
		end

		$display("Jobs: %0d, data errors: %0d, protocol errors: %0d",
			NUM_JOBS, data_errors, proto_errors);
		if (data_errors + proto_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
